// File: run.sh
#!/bin/sh
# Build and run the retry stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module retry_tmr_tb \
    -f src.f \
    -o sim_retry_tmr

./obj_dir/sim_retry_tmr | tee sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

// File: source/redundant_lane.sv
`timescale 1ns/1ps
`include "retry_cfg.svh"

module redundant_lane (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  retry_pkg::item_t            item_i,
    input  logic                        valid_i,
    output logic                        ready_o,

    // Bit flips applied at capture
    input  logic [`RETRY_DATA_W-1:0]    fault_i,

    output retry_pkg::item_t            item_o,
    output logic                        valid_o,
    input  logic                        ready_i
);

    localparam int W = `RETRY_DATA_W;

    logic               valid_q;
    retry_pkg::item_t   item_q;

    // Multiply by the odd constant, mix in a rotate left by 5
    function automatic logic [W-1:0] mix(input logic [W-1:0] d);
        logic [W-1:0] prod;
        prod = d * `RETRY_MIX_CONST;
        return prod ^ {d[W-6:0], d[W-1:W-5]};
    endfunction

    assign ready_o = ready_i | ~valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload stage
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            item_q.data <= mix(item_i.data) ^ fault_i;
            item_q.id   <= item_i.id;
        end
    end

    assign item_o  = item_q;
    assign valid_o = valid_q;

endmodule

// File: source/retry_cfg.svh
`ifndef RETRY_CFG_SVH
`define RETRY_CFG_SVH

// Sequence id width
// Top bit is parity, lower bits pick one of the replay slots
`define RETRY_ID_W 4

// Payload width of one item
`define RETRY_DATA_W 16

// Redundant lanes, two only detect a fault
`define RETRY_NUM_LANES 2

// Odd multiplier of the lane transform
`define RETRY_MIX_CONST 16'h9E37

`endif

// File: source/retry_inorder_end.sv
`timescale 1ns/1ps
`include "retry_cfg.svh"

module retry_inorder_end (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,

    // From the lanes
    input  retry_pkg::item_t [`RETRY_NUM_LANES-1:0]         lane_item_i,
    input  logic [`RETRY_NUM_LANES-1:0]                     lane_valid_i,
    output logic                                            lane_ready_o,

    // Downstream
    output logic [`RETRY_DATA_W-1:0]                        data_o,
    output logic                                            valid_o,
    input  logic                                            ready_i,

    // Retry path to the start block
    output retry_pkg::retry_req_t                           retry_o,
    input  logic                                            retry_ready_i
);

    retry_pkg::seq_id_u exp_q;
    logic               lock_q;
    logic               any_valid;
    logic               agree;
    logic               id_ok;
    logic               good;
    logic               consume;
    logic               drop;
    logic               deliver;

    //////////////////////////////////////////////////
    // Lane compare and order check

    always_comb begin
        agree = &lane_valid_i;
        for (int i = 1; i < `RETRY_NUM_LANES; i++) begin
            if (lane_item_i[i] != lane_item_i[0]) begin
                agree = 1'b0;
            end
        end
    end

    assign any_valid = |lane_valid_i;
    assign id_ok     = (lane_item_i[0].id.raw == exp_q.raw);
    assign good      = any_valid & agree & id_ok;

    // Bad items wait until start can take the failed id
    assign lane_ready_o = good ? ready_i : retry_ready_i;

    assign consume = any_valid & lane_ready_o;
    assign drop    = consume & ~good;
    assign deliver = good & ready_i;

    //////////////////////////////////////////////////
    // Outputs

    assign data_o  = lane_item_i[0].data;
    assign valid_o = good;

    // Lock rises in the cycle the failure is seen
    always_comb begin
        retry_o.valid = drop;
        retry_o.lock  = lock_q | (any_valid & ~good);
        retry_o.id    = lane_item_i[0].id;
    end

    //////////////////////////////////////////////////
    // Expected id and lock state

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_q <= '0;
        end else if (consume) begin
            // Start gives every issue a new id, so each consumed item steps the count
            exp_q <= retry_pkg::next_id(exp_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
        end else if (drop) begin
            lock_q <= 1'b1;
        end else if (deliver) begin
            lock_q <= 1'b0;
        end
    end

endmodule

// File: source/retry_inorder_start.sv
`timescale 1ns/1ps
`include "retry_cfg.svh"

module retry_inorder_start (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Upstream
    input  logic [`RETRY_DATA_W-1:0]    data_i,
    input  logic                        valid_i,
    output logic                        ready_o,

    // Towards the lanes
    output retry_pkg::item_t            item_o,
    output logic                        valid_o,
    input  logic                        ready_i,

    // Retry path from the end block
    input  retry_pkg::retry_req_t       retry_i,
    output logic                        retry_ready_o
);

    localparam int SLOTS = 2 ** (`RETRY_ID_W - 1);

    logic                       run_q;
    logic                       failed_valid_q;
    retry_pkg::seq_id_u         failed_id_q;
    retry_pkg::seq_id_u         cnt_q;
    logic [`RETRY_DATA_W-1:0]   store_q [SLOTS];
    logic                       issue;

    //////////////////////////////////////////////////
    // Failed id, held until the replay is issued

    assign retry_ready_o = ready_i | ~failed_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            failed_valid_q <= 1'b0;
        end else if (retry_i.valid && retry_ready_o) begin
            failed_valid_q <= 1'b1;
        end else if (ready_i) begin
            failed_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            failed_id_q <= '0;
        end else if (retry_i.valid && retry_ready_o) begin
            failed_id_q <= retry_i.id;
        end
    end

    // Input stays closed for the first cycle out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Id counter with parity tag

    assign issue = valid_o & ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (issue) begin
            cnt_q <= retry_pkg::next_id(cnt_q);
        end
    end

    //////////////////////////////////////////////////
    // Replay buffer, one slot per id

    always_ff @(posedge clk_i) begin
        if (issue) begin
            store_q[cnt_q.f.slot] <= item_o.data;
        end
    end

    // Replay wins over new input and always gets a fresh id
    always_comb begin
        if (failed_valid_q) begin
            item_o.data = store_q[failed_id_q.f.slot];
        end else begin
            item_o.data = data_i;
        end
        item_o.id = cnt_q;
    end

    //////////////////////////////////////////////////
    // Handshake

    assign valid_o = failed_valid_q | (run_q & valid_i & ~retry_i.lock);
    assign ready_o = run_q & ready_i & ~failed_valid_q & ~retry_i.lock;

endmodule

// File: source/retry_pkg.sv
`include "retry_cfg.svh"

package retry_pkg;

    // Field view of a sequence id
    typedef struct packed {
        logic                      parity;
        logic [`RETRY_ID_W-2:0]    slot;
    } id_fields_t;

    // One id word, read raw for order checks or split for slot lookup
    typedef union packed {
        logic [`RETRY_ID_W-1:0]    raw;
        id_fields_t                f;
    } seq_id_u;

    typedef struct packed {
        logic [`RETRY_DATA_W-1:0]  data;
        seq_id_u                   id;
    } item_t;

    // Request from end block back to start block
    typedef struct packed {
        logic                      valid;
        logic                      lock;
        seq_id_u                   id;
    } retry_req_t;

    // Parity counter step, shared by start and end
    function automatic seq_id_u next_id(input seq_id_u id);
        seq_id_u nxt;
        nxt.f.slot   = id.f.slot + 1'b1;
        nxt.f.parity = ^nxt.f.slot;
        return nxt;
    endfunction

endpackage

// File: source/retry_tmr_top.sv
`timescale 1ns/1ps
`include "retry_cfg.svh"

module retry_tmr_top (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,

    input  logic [`RETRY_DATA_W-1:0]                        in_data_i,
    input  logic                                            in_valid_i,
    output logic                                            in_ready_o,

    output logic [`RETRY_DATA_W-1:0]                        out_data_o,
    output logic                                            out_valid_o,
    input  logic                                            out_ready_i,

    // One fault word per lane
    input  logic [`RETRY_NUM_LANES-1:0][`RETRY_DATA_W-1:0]  lane_fault_i
);

    retry_pkg::item_t                               start_item;
    logic                                           start_valid;
    logic                                           lanes_ready;
    logic [`RETRY_NUM_LANES-1:0]                    lane_ready;
    retry_pkg::item_t [`RETRY_NUM_LANES-1:0]        lane_item;
    logic [`RETRY_NUM_LANES-1:0]                    lane_valid;
    logic                                           end_ready;
    retry_pkg::retry_req_t                          retry;
    logic                                           retry_ready;

    retry_inorder_start u_start (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .data_i         (in_data_i),
        .valid_i        (in_valid_i),
        .ready_o        (in_ready_o),
        .item_o         (start_item),
        .valid_o        (start_valid),
        .ready_i        (lanes_ready),
        .retry_i        (retry),
        .retry_ready_o  (retry_ready)
    );

    // Lockstep lanes, all readies equal
    assign lanes_ready = &lane_ready;

    for (genvar g = 0; g < `RETRY_NUM_LANES; g++) begin : g_lane
        redundant_lane u_lane (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .item_i     (start_item),
            .valid_i    (start_valid),
            .ready_o    (lane_ready[g]),
            .fault_i    (lane_fault_i[g]),
            .item_o     (lane_item[g]),
            .valid_o    (lane_valid[g]),
            .ready_i    (end_ready)
        );
    end

    retry_inorder_end u_end (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lane_item_i    (lane_item),
        .lane_valid_i   (lane_valid),
        .lane_ready_o   (end_ready),
        .data_o         (out_data_o),
        .valid_o        (out_valid_o),
        .ready_i        (out_ready_i),
        .retry_o        (retry),
        .retry_ready_i  (retry_ready)
    );

endmodule

// File: src.f
+incdir+source
source/retry_pkg.sv
source/redundant_lane.sv
source/retry_inorder_start.sv
source/retry_inorder_end.sv
source/retry_tmr_top.sv
tb/retry_tmr_tb.sv

// File: tb/retry_tmr_tb.sv
`timescale 1ns/1ps
`include "retry_cfg.svh"

module retry_tmr_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_ITEMS       = 400;
    localparam int CYCLES_PER_ITEM = 20;
    localparam int W               = `RETRY_DATA_W;
    localparam int LANES           = `RETRY_NUM_LANES;

    logic                       clk_i;
    logic                       rst_n_i;
    logic [W-1:0]               in_data_i;
    logic                       in_valid_i;
    logic                       in_ready_o;
    logic [W-1:0]               out_data_o;
    logic                       out_valid_o;
    logic                       out_ready_i;
    logic [LANES-1:0][W-1:0]    lane_fault_i;

    integer         seed;
    int             cycle;
    int             accepted;
    int             delivered;
    int             mismatch_cnt;
    int             other_cnt;
    int             faults_sent;
    string          test_name;
    logic [W-1:0]   model_q[$];
    int             accept_cycle_q[$];

    retry_tmr_top dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .lane_fault_i   (lane_fault_i)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Reference model

    // Low half of the product with the odd constant XOR a left rotate by 5
    function automatic logic [W-1:0] expected_result(input logic [W-1:0] d);
        logic [2*W-1:0] wide;
        logic [W-1:0]   rot;
        wide = d * `RETRY_MIX_CONST;
        rot  = (d << 5) | (d >> (W - 5));
        return wide[W-1:0] ^ rot;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and checks

    task automatic drive_inputs(input bit with_faults, input bit with_stall);
        logic [31:0] r;
        int          lane;
        int          bit_pos;
        r            = $random(seed);
        in_valid_i   = (r[2:0] != 3'd0);
        out_ready_i  = with_stall ? r[3] : 1'b1;
        in_data_i    = $random(seed);
        lane_fault_i = '0;
        if (with_faults) begin
            r = $random(seed);
            // Roughly one cycle in ten flips a single bit in one lane
            if (r % 10 == 0) begin
                r       = $random(seed);
                lane    = r[15:0] % LANES;
                bit_pos = r[31:16] % W;
                lane_fault_i[lane][bit_pos] = 1'b1;
            end
        end
    endtask

    task automatic sample_outputs(input bit timed);
        logic [W-1:0] exp_data;
        int           exp_cycle;
        cycle++;
        if (out_valid_o && out_ready_i) begin
            delivered++;
            if (model_q.size() == 0) begin
                $display("%s: result %h delivered with no input pending", test_name, out_data_o);
                other_cnt++;
            end else begin
                exp_data  = model_q.pop_front();
                exp_cycle = accept_cycle_q.pop_front();
                if (out_data_o !== exp_data) begin
                    $display("mismatch %s: expected %h, actual %h",
                             test_name, exp_data, out_data_o);
                    mismatch_cnt++;
                end
                if (exp_cycle >= 0 && cycle != exp_cycle + 1) begin
                    $display("mismatch %s latency: expected %0d, actual %0d",
                             test_name, 1, cycle - exp_cycle);
                    mismatch_cnt++;
                end
            end
        end
        if (in_valid_i && in_ready_o) begin
            model_q.push_back(expected_result(in_data_i));
            accept_cycle_q.push_back(timed ? cycle : -1);
            accepted++;
            // Flip lands on the item the lanes capture at the next edge
            if (lane_fault_i != '0) begin
                faults_sent++;
            end
        end
    endtask

    task automatic run_phase(input string name, input bit with_faults, input bit with_stall,
                             input bit timed, input int count);
        int target;
        test_name = name;
        target    = accepted + count;
        while (accepted < target) begin
            @(posedge clk_i);
            #1;
            drive_inputs(with_faults, with_stall);
            @(negedge clk_i);
            sample_outputs(timed);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        #1;
        in_valid_i   = 1'b0;
        lane_fault_i = '0;
        out_ready_i  = 1'b1;
        @(negedge clk_i);
        sample_outputs(1'b0);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        seed         = 32'h1b1e9e4e;
        cycle        = 0;
        accepted     = 0;
        delivered    = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        faults_sent  = 0;
        test_name    = "reset";
        rst_n_i      = 1'b0;
        in_data_i    = '0;
        in_valid_i   = 1'b0;
        out_ready_i  = 1'b0;
        lane_fault_i = '0;

        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        if (out_valid_o !== 1'b0) begin
            $display("mismatch reset out_valid_o: expected %b, actual %b", 1'b0, out_valid_o);
            mismatch_cnt++;
        end
        if (in_ready_o !== 1'b0) begin
            $display("mismatch reset in_ready_o: expected %b, actual %b", 1'b0, in_ready_o);
            mismatch_cnt++;
        end

        run_phase("clean_stream", 1'b0, 1'b0, 1'b1, NUM_ITEMS / 4);
        run_phase("lane_faults", 1'b1, 1'b0, 1'b0, NUM_ITEMS / 4);
        run_phase("back_pressure", 1'b0, 1'b1, 1'b0, NUM_ITEMS / 4);
        run_phase("faults_and_stall", 1'b1, 1'b1, 1'b0, NUM_ITEMS / 4);

        // Let everything in flight come out and then watch for stray results
        test_name = "drain";
        while (model_q.size() != 0) begin
            idle_cycle();
        end
        repeat (5) idle_cycle();

        if (delivered != accepted) begin
            $display("mismatch %s output count: expected %0d, actual %0d",
                     test_name, accepted, delivered);
            mismatch_cnt++;
        end
        if (faults_sent == 0) begin
            $display("No fault hit an accepted item during the fault phases");
            other_cnt++;
        end

        $display("Errors: %0d mismatches, %0d other failures (%0d items, %0d faults)",
                 mismatch_cnt, other_cnt, accepted, faults_sent);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Generous upper bound on the run for every item
    initial begin
        #(NUM_ITEMS * CYCLES_PER_ITEM * CLK_PERIOD);
        $display("Watchdog expired before all items were delivered");
        $display("Test failed");
        $finish;
    end

endmodule
